// ==== common/gat_pkg.sv ====
`default_nettype none

package gat_pkg;

  // Datapath sizes
  localparam int DATA_WIDTH      = 8;
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int MAX_NODES       = 8;

  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  localparam int NUM_NODE_WIDTH  = $clog2(MAX_NODES);

  // Wh needs headroom for 16 products of two bytes
  localparam int WH_DATA_WIDTH   = 20;
  localparam int COEF_WIDTH      = 32;

  // W row by row followed by the left and right attention halves
  localparam int A_LEFT_BASE     = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int A_RIGHT_BASE    = A_LEFT_BASE + NUM_FEATURE_OUT;
  localparam int WEIGHT_DEPTH    = A_RIGHT_BASE + NUM_FEATURE_OUT;
  localparam int WEIGHT_ADDR_W   = $clog2(WEIGHT_DEPTH);

  // Negative slope of 1/8
  localparam int LRELU_SHIFT     = 3;

  // Element 0 sits in the low bits
  typedef logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh_row_t;
  typedef logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0]    wgt_row_t;

  typedef enum logic {
    WAIT_WGT = 1'b0,
    RUN      = 1'b1
  } decode_state_e;

endpackage

`default_nettype wire

// ==== logic/weight_bank.sv ====
`default_nettype none

module weight_bank (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wgt_we_i,
  input  logic [gat_pkg::WEIGHT_ADDR_W-1:0] wgt_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]    wgt_din_i,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0] rd_row_i,
  output gat_pkg::wgt_row_t                 w_row_o,
  output gat_pkg::wgt_row_t                 a_left_o,
  output gat_pkg::wgt_row_t                 a_right_o
);

  import gat_pkg::*;

  logic [DATA_WIDTH-1:0]    mem_q [WEIGHT_DEPTH];
  logic [WEIGHT_ADDR_W-1:0] row_base;

  // Start of the W row selected by the entry column
  assign row_base = WEIGHT_ADDR_W'(rd_row_i) * WEIGHT_ADDR_W'(NUM_FEATURE_OUT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < WEIGHT_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wgt_we_i && (wgt_addr_i < WEIGHT_ADDR_W'(WEIGHT_DEPTH))) begin
      mem_q[wgt_addr_i] <= wgt_din_i;
    end
  end

  genvar k;
  generate
    for (k = 0; k < NUM_FEATURE_OUT; k++) begin : g_rd
      assign w_row_o[k]   = mem_q[row_base + k];
      assign a_left_o[k]  = mem_q[A_LEFT_BASE + k];
      assign a_right_o[k] = mem_q[A_RIGHT_BASE + k];
    end
  endgenerate

endmodule

`default_nettype wire

// ==== spmm/spmm_decode.sv ====
`default_nettype none

module spmm_decode (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wgt_load_done_i,
  input  logic                               h_vld_i,
  input  logic                               h_sub_first_i,
  input  logic                               h_row_last_i,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]  h_col_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] h_val_i,
  output logic                               ent_vld_o,
  output logic [gat_pkg::COL_IDX_WIDTH-1:0]  ent_col_o,
  output logic signed [gat_pkg::DATA_WIDTH-1:0] ent_val_o,
  output logic                               ent_last_o,
  output logic                               ent_first_o,
  output logic [gat_pkg::NUM_NODE_WIDTH-1:0] ent_node_o
);

  import gat_pkg::*;

  decode_state_e             state_q;
  logic                      accept;
  logic                      row_start_q;
  logic                      first_hold_q;
  logic                      cur_first;
  logic [NUM_NODE_WIDTH-1:0] node_cnt_q;
  logic [NUM_NODE_WIDTH-1:0] cur_node;

  assign accept = (state_q == RUN) && h_vld_i;

  // Subgraph flag is taken from the row's opening entry only
  assign cur_first = row_start_q ? h_sub_first_i : first_hold_q;
  assign cur_node  = (row_start_q && h_sub_first_i) ? '0 : node_cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WAIT_WGT;
    end else begin
      case (state_q)
        WAIT_WGT: begin
          if (wgt_load_done_i) begin
            state_q <= RUN;
          end
        end
        RUN:     state_q <= RUN;
        default: state_q <= WAIT_WGT;
      endcase
    end
  end

  // Row and node boundaries
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_start_q  <= 1'b1;
      first_hold_q <= 1'b0;
      node_cnt_q   <= '0;
      ent_vld_o    <= 1'b0;
    end else begin
      ent_vld_o <= accept;
      if (accept) begin
        row_start_q  <= h_row_last_i;
        first_hold_q <= cur_first;
        node_cnt_q   <= h_row_last_i ? cur_node + 1'b1 : cur_node;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ent_col_o   <= h_col_i;
      ent_val_o   <= h_val_i;
      ent_last_o  <= h_row_last_i;
      ent_first_o <= cur_first;
      ent_node_o  <= cur_node;
    end
  end

endmodule

`default_nettype wire

// ==== spmm/sppe_array.sv ====
`default_nettype none

module sppe_array (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  ent_vld_i,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]     ent_col_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] ent_val_i,
  input  logic                                  ent_last_i,
  input  logic                                  ent_first_i,
  input  logic [gat_pkg::NUM_NODE_WIDTH-1:0]    ent_node_i,
  input  gat_pkg::wgt_row_t                     w_row_i,
  output logic [gat_pkg::COL_IDX_WIDTH-1:0]     rd_row_o,
  output logic                                  wh_vld_o,
  output gat_pkg::wh_row_t                      wh_row_o,
  output logic                                  wh_first_o,
  output logic [gat_pkg::NUM_NODE_WIDTH-1:0]    wh_node_o
);

  import gat_pkg::*;

  logic signed [2*DATA_WIDTH-1:0]  prod  [NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] sum   [NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] acc_q [NUM_FEATURE_OUT];

  // Entry column selects the W row
  assign rd_row_o = ent_col_i;

  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      prod[k] = ent_val_i * $signed(w_row_i[k]);
      sum[k]  = acc_q[k] + prod[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o <= 1'b0;
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        acc_q[k] <= '0;
      end
    end else begin
      wh_vld_o <= ent_vld_i && ent_last_i;
      if (ent_vld_i) begin
        // Lanes restart on the row's last entry
        for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
          acc_q[k] <= ent_last_i ? '0 : sum[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ent_vld_i && ent_last_i) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        wh_row_o[k] <= sum[k];
      end
      wh_first_o <= ent_first_i;
      wh_node_o  <= ent_node_i;
    end
  end

endmodule

`default_nettype wire

// ==== dmvm/attn_score.sv ====
`default_nettype none

module attn_score (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wh_vld_i,
  input  gat_pkg::wh_row_t                      wh_row_i,
  input  logic                                  wh_first_i,
  input  logic [gat_pkg::NUM_NODE_WIDTH-1:0]    wh_node_i,
  input  gat_pkg::wgt_row_t                     a_left_i,
  input  gat_pkg::wgt_row_t                     a_right_i,
  output logic                                  out_vld_o,
  output logic [gat_pkg::NUM_NODE_WIDTH-1:0]    out_node_o,
  output gat_pkg::wh_row_t                      out_wh_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] out_coef_o
);

  import gat_pkg::*;

  logic signed [COEF_WIDTH-1:0] proj_left;
  logic signed [COEF_WIDTH-1:0] proj_right;
  logic signed [COEF_WIDTH-1:0] target_left_q;
  logic signed [COEF_WIDTH-1:0] coef_sum;
  logic signed [COEF_WIDTH-1:0] coef_act;

  function automatic logic signed [COEF_WIDTH-1:0] dot_row(
    input wgt_row_t a,
    input wh_row_t  wh
  );
    logic signed [COEF_WIDTH-1:0] acc;
    acc = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc = acc + $signed(a[k]) * $signed(wh[k]);
    end
    return acc;
  endfunction

  assign proj_left  = dot_row(a_left_i, wh_row_i);
  assign proj_right = dot_row(a_right_i, wh_row_i);

  // Target row scores against itself with the fresh projection
  assign coef_sum = (wh_first_i ? proj_left : target_left_q) + proj_right;

  // Leaky ReLU with a floor shift for negatives
  assign coef_act = coef_sum[COEF_WIDTH-1] ? (coef_sum >>> LRELU_SHIFT) : coef_sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld_o     <= 1'b0;
      target_left_q <= '0;
    end else begin
      out_vld_o <= wh_vld_i;
      if (wh_vld_i && wh_first_i) begin
        target_left_q <= proj_left;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      out_node_o <= wh_node_i;
      out_wh_o   <= wh_row_i;
      out_coef_o <= coef_act;
    end
  end

endmodule

`default_nettype wire

// ==== logic/gat_layer.sv ====
`default_nettype none

module gat_layer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wgt_we_i,
  input  logic [gat_pkg::WEIGHT_ADDR_W-1:0]     wgt_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]        wgt_din_i,
  input  logic                                  wgt_load_done_i,
  input  logic                                  h_vld_i,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]     h_col_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] h_val_i,
  input  logic                                  h_row_last_i,
  input  logic                                  h_sub_first_i,
  output logic                                  out_vld_o,
  output logic [gat_pkg::NUM_NODE_WIDTH-1:0]    out_node_o,
  output gat_pkg::wh_row_t                      out_wh_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] out_coef_o
);

  import gat_pkg::*;

  // Decode to MAC lanes
  logic                         ent_vld;
  logic [COL_IDX_WIDTH-1:0]     ent_col;
  logic signed [DATA_WIDTH-1:0] ent_val;
  logic                         ent_last;
  logic                         ent_first;
  logic [NUM_NODE_WIDTH-1:0]    ent_node;

  // Bank read paths
  logic [COL_IDX_WIDTH-1:0]     rd_row;
  wgt_row_t                     w_row;
  wgt_row_t                     a_left;
  wgt_row_t                     a_right;

  // MAC lanes to score stage
  logic                         wh_vld;
  wh_row_t                      wh_row;
  logic                         wh_first;
  logic [NUM_NODE_WIDTH-1:0]    wh_node;

  weight_bank u_weight_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_din_i  (wgt_din_i),
    .rd_row_i   (rd_row),
    .w_row_o    (w_row),
    .a_left_o   (a_left),
    .a_right_o  (a_right)
  );

  spmm_decode u_spmm_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_load_done_i (wgt_load_done_i),
    .h_vld_i         (h_vld_i),
    .h_sub_first_i   (h_sub_first_i),
    .h_row_last_i    (h_row_last_i),
    .h_col_i         (h_col_i),
    .h_val_i         (h_val_i),
    .ent_vld_o       (ent_vld),
    .ent_col_o       (ent_col),
    .ent_val_o       (ent_val),
    .ent_last_o      (ent_last),
    .ent_first_o     (ent_first),
    .ent_node_o      (ent_node)
  );

  sppe_array u_sppe_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .ent_vld_i   (ent_vld),
    .ent_col_i   (ent_col),
    .ent_val_i   (ent_val),
    .ent_last_i  (ent_last),
    .ent_first_i (ent_first),
    .ent_node_i  (ent_node),
    .w_row_i     (w_row),
    .rd_row_o    (rd_row),
    .wh_vld_o    (wh_vld),
    .wh_row_o    (wh_row),
    .wh_first_o  (wh_first),
    .wh_node_o   (wh_node)
  );

  attn_score u_attn_score (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_vld_i   (wh_vld),
    .wh_row_i   (wh_row),
    .wh_first_i (wh_first),
    .wh_node_i  (wh_node),
    .a_left_i   (a_left),
    .a_right_i  (a_right),
    .out_vld_o  (out_vld_o),
    .out_node_o (out_node_o),
    .out_wh_o   (out_wh_o),
    .out_coef_o (out_coef_o)
  );

endmodule

`default_nettype wire

// ==== bench/gat_checker.sv ====
`default_nettype none

module gat_checker (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               wgt_load_done_i,
  input logic                               h_vld_i,
  input logic                               h_row_last_i,
  input logic                               out_vld_i,
  input logic [gat_pkg::NUM_NODE_WIDTH-1:0] out_node_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  logic                      run_q;
  logic                      last_accept;
  logic [NUM_NODE_WIDTH-1:0] prev_node_q;

  // Mirrors the decode FSM leaving WAIT_WGT
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else if (wgt_load_done_i) begin
      run_q <= 1'b1;
    end
  end

  // Node index of the previous result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_node_q <= '0;
    end else if (out_vld_i) begin
      prev_node_q <= out_node_i;
    end
  end

  assign last_accept = run_q && h_vld_i && h_row_last_i;

  a_quiet_until_loaded: assert property (
    @(posedge clk) (!rst_n || !wgt_load_done_i) |-> !out_vld_i
  ) else $error("out_vld_o high before weights were loaded");

  a_row_latency: assert property (
    @(posedge clk) disable iff (!rst_n) out_vld_i == $past(last_accept, 3)
  ) else $error("out_vld_o not 3 cycles after an accepted last entry");

  a_node_step: assert property (
    @(posedge clk) disable iff (!rst_n)
      out_vld_i |-> (out_node_i == '0 || out_node_i == prev_node_q + 1'b1)
  ) else $error("out_node_o neither restarts at 0 nor follows the previous node");

endmodule

`default_nettype wire

// ==== bench/gat_tb.sv ====
`default_nettype none

module gat_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  typedef struct packed {
    int                        due;
    logic [NUM_NODE_WIDTH-1:0] node;
    wh_row_t                   wh;
    logic [COEF_WIDTH-1:0]     coef;
  } expect_t;

  logic                         clk;
  logic                         rst_n;
  logic                         wgt_we;
  logic [WEIGHT_ADDR_W-1:0]     wgt_addr;
  logic [DATA_WIDTH-1:0]        wgt_din;
  logic                         wgt_load_done;
  logic                         h_vld;
  logic [COL_IDX_WIDTH-1:0]     h_col;
  logic signed [DATA_WIDTH-1:0] h_val;
  logic                         h_row_last;
  logic                         h_sub_first;
  logic                         out_vld;
  logic [NUM_NODE_WIDTH-1:0]    out_node;
  wh_row_t                      out_wh;
  logic signed [COEF_WIDTH-1:0] out_coef;

  integer  seed = 24;
  int      cyc = 0;
  int      node_m = 0;
  longint  tgt_left = 0;
  logic signed [DATA_WIDTH-1:0] bank_m [WEIGHT_DEPTH];
  expect_t exp_q [$];

  gat_layer u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_we_i        (wgt_we),
    .wgt_addr_i      (wgt_addr),
    .wgt_din_i       (wgt_din),
    .wgt_load_done_i (wgt_load_done),
    .h_vld_i         (h_vld),
    .h_col_i         (h_col),
    .h_val_i         (h_val),
    .h_row_last_i    (h_row_last),
    .h_sub_first_i   (h_sub_first),
    .out_vld_o       (out_vld),
    .out_node_o      (out_node),
    .out_wh_o        (out_wh),
    .out_coef_o      (out_coef)
  );

  bind gat_layer gat_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_load_done_i (wgt_load_done_i),
    .h_vld_i         (h_vld_i),
    .h_row_last_i    (h_row_last_i),
    .out_vld_i       (out_vld_o),
    .out_node_i      (out_node_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_equal(input longint got, input longint exp, input string what);
    if (got != exp) begin
      stop_on_error($sformatf("MISMATCH at time %0t: %s got %0d expected %0d",
                              $time, what, got, exp));
    end
  endtask

  // Mostly negative weights so the leaky slope gets exercised
  function automatic logic signed [DATA_WIDTH-1:0] rand_weight();
    int mag;
    bit neg;
    mag = $random(seed) & 127;
    neg = ($random(seed) & 3) != 0;
    return neg ? DATA_WIDTH'(-mag) : DATA_WIDTH'(mag);
  endfunction

  function automatic longint attn_dot(input int base, input int wh [NUM_FEATURE_OUT]);
    longint acc;
    acc = 0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc += longint'(bank_m[base + k]) * wh[k];
    end
    return acc;
  endfunction

  // Floor division by the slope divisor for negatives
  function automatic longint leaky_relu(input longint c);
    longint d;
    d = longint'(1) << LRELU_SHIFT;
    if (c >= 0) begin
      return c;
    end
    return -((-c + d - 1) / d);
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    h_vld  <= 1'b0;
    wgt_we <= 1'b0;
  endtask

  task automatic load_weights();
    logic signed [DATA_WIDTH-1:0] w;
    for (int a = 0; a < WEIGHT_DEPTH; a++) begin
      w = rand_weight();
      @(posedge clk);
      wgt_we   <= 1'b1;
      wgt_addr <= WEIGHT_ADDR_W'(a);
      wgt_din  <= w;
      bank_m[a] = w;
    end
    idle_cycle();
  endtask

  task automatic send_discarded(input int n);
    for (int j = 0; j < n; j++) begin
      @(posedge clk);
      h_vld       <= 1'b1;
      h_col       <= COL_IDX_WIDTH'($random(seed));
      h_val       <= DATA_WIDTH'($random(seed));
      h_row_last  <= 1'($random(seed));
      h_sub_first <= 1'($random(seed));
    end
    idle_cycle();
  endtask

  task automatic send_row(input bit first, input int nnz, input bit gaps);
    int                           acc [NUM_FEATURE_OUT];
    int                           col;
    logic signed [DATA_WIDTH-1:0] val;
    longint                       right;
    expect_t                      e;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc[k] = 0;
    end
    if (first) begin
      node_m = 0;
    end
    for (int j = 0; j < nnz; j++) begin
      if (gaps && (($random(seed) & 3) == 0)) begin
        idle_cycle();
      end
      col = $random(seed) & (NUM_FEATURE_IN - 1);
      val = DATA_WIDTH'($random(seed));
      @(posedge clk);
      h_vld       <= 1'b1;
      h_col       <= COL_IDX_WIDTH'(col);
      h_val       <= val;
      h_row_last  <= (j == nnz - 1);
      h_sub_first <= first;
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        acc[k] += int'(val) * int'(bank_m[col * NUM_FEATURE_OUT + k]);
      end
    end
    if (first) begin
      tgt_left = attn_dot(A_LEFT_BASE, acc);
    end
    right = attn_dot(A_RIGHT_BASE, acc);
    // Accepted on the next edge, visible at the fourth falling edge from now
    e.due  = cyc + 4;
    e.node = NUM_NODE_WIDTH'(node_m);
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      e.wh[k] = WH_DATA_WIDTH'(acc[k]);
    end
    e.coef = COEF_WIDTH'(leaky_relu(tgt_left + right));
    exp_q.push_back(e);
    node_m++;
  endtask

  task automatic send_subgraph(input int nrows, input int max_nnz, input bit gaps);
    for (int r = 0; r < nrows; r++) begin
      send_row(r == 0, 1 + (($random(seed) & 32'h7fff) % max_nnz), gaps);
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      stop_on_error("timeout: results still pending after the drain limit");
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    expect_t e;
    cyc = cyc + 1;
    if (out_vld) begin
      if (exp_q.size() == 0) begin
        stop_on_error("output strobe seen with no row pending");
      end else begin
        e = exp_q.pop_front();
        check_equal(cyc, e.due, "out_vld_o cycle");
        check_equal(out_node, e.node, "out_node_o");
        for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
          check_equal($signed(out_wh[k]), $signed(e.wh[k]), $sformatf("out_wh_o[%0d]", k));
        end
        check_equal(out_coef, $signed(e.coef), "out_coef_o");
      end
    end else if (exp_q.size() > 0 && cyc >= exp_q[0].due) begin
      stop_on_error("no output strobe in the cycle a row result was due");
    end
  end

  initial begin
    rst_n         <= 1'b0;
    wgt_we        <= 1'b0;
    wgt_addr      <= '0;
    wgt_din       <= '0;
    wgt_load_done <= 1'b0;
    h_vld         <= 1'b0;
    h_col         <= '0;
    h_val         <= '0;
    h_row_last    <= 1'b0;
    h_sub_first   <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Dropped while decode still waits for weights
    send_discarded(6);
    repeat (10) idle_cycle();

    load_weights();
    @(posedge clk);
    wgt_load_done <= 1'b1;
    repeat (2) idle_cycle();

    for (int s = 0; s < 10; s++) begin
      send_subgraph(1 + ($random(seed) & 7), 6, 1'b1);
    end

    // Single-entry rows back to back
    send_subgraph(8, 1, 1'b0);
    send_subgraph(5, 1, 1'b0);
    send_subgraph(4, 6, 1'b0);
    idle_cycle();

    wait_drain(50);
    // Quiet tail so a stray strobe is still caught
    repeat (5) idle_cycle();

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/gat_pkg.sv
logic/weight_bank.sv
spmm/spmm_decode.sv
spmm/sppe_array.sv
dmvm/attn_score.sv
logic/gat_layer.sv
bench/gat_checker.sv
bench/gat_tb.sv

// ==== Makefile ====
# Verilator flow for the GAT layer testbench

VERILATOR ?= verilator
TOP       ?= gat_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test passed" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
